// ==== source/ttc_pkg.sv ====
`default_nettype none

package ttc_pkg;

   // ----------------------------------------
   // Sizes and base types
   // ----------------------------------------
   localparam int num_timers  = 3;
   localparam int addr_w      = 8;
   localparam int data_w      = 32;
   localparam int count_w     = 16;
   localparam int num_strobes = 6;   // One per writable register

   typedef logic [addr_w-1:0]      apb_addr_t;
   typedef logic [data_w-1:0]      apb_data_t;
   typedef logic [count_w-1:0]     count_t;      // Counter, interval and match
   typedef logic [4:0]             clk_ctrl_t;   // Exponent and prescale enable
   typedef logic [3:0]             cntr_ctrl_t;
   typedef logic [2:0]             int_t;        // Status and enable share layout
   typedef logic [num_strobes-1:0] reg_strobe_t;

   // ----------------------------------------
   // Register map
   // ----------------------------------------
   localparam int kind_msb = 7;      // paddr[7:4] picks the register
   localparam int kind_lsb = 4;
   localparam int tidx_msb = 3;      // paddr[3:2] picks the timer
   localparam int tidx_lsb = 2;

   typedef enum logic [3:0] {
      reg_clk_ctrl   = 4'd0,
      reg_cntr_ctrl  = 4'd1,
      reg_count      = 4'd2,         // Read only
      reg_interval   = 4'd3,
      reg_match      = 4'd4,
      reg_int_status = 4'd5,         // Clears on read
      reg_int_enable = 4'd6
   } reg_kind_t;

   // Strobe bit positions
   localparam int stb_clk_ctrl   = 0;
   localparam int stb_cntr_ctrl  = 1;
   localparam int stb_interval   = 2;
   localparam int stb_match      = 3;
   localparam int stb_int_status = 4;   // Write one to clear
   localparam int stb_int_enable = 5;

   // ----------------------------------------
   // Control fields
   // ----------------------------------------
   localparam int ck_pre_en    = 0;
   localparam int ck_exp_lsb   = 1;
   localparam int ck_exp_msb   = 4;
   localparam int cc_run       = 0;
   localparam int cc_interval  = 1;
   localparam int cc_match_en  = 2;
   localparam int cc_restart   = 3;     // Self clearing
   localparam int int_overflow = 0;
   localparam int int_interval = 1;
   localparam int int_match    = 2;

   // APB phase tracker
   typedef enum logic [1:0] {
      apb_idle,
      apb_setup,
      apb_access
   } apb_state_t;

endpackage

`default_nettype wire

// ==== source/ttc_reg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Register bundle of one timer
interface ttc_reg_if import ttc_pkg::*; ();

   // Decoder side
   reg_strobe_t wr_strobe;   // One hot, access cycle only
   count_t      wdata;       // Low half of pwdata
   logic        rd_clear;    // Status read in progress

   // Timer side, live register values
   clk_ctrl_t   clk_ctrl;
   cntr_ctrl_t  cntr_ctrl;
   count_t      count;
   count_t      interval;
   count_t      match;
   int_t        int_status;
   int_t        int_enable;

   modport ctrl (
      output wr_strobe, wdata, rd_clear,
      input  clk_ctrl, cntr_ctrl, count, interval, match,
      input  int_status, int_enable
   );

   modport timer (
      input  wr_strobe, wdata, rd_clear,
      output clk_ctrl, cntr_ctrl, count, interval, match,
      output int_status, int_enable
   );

endinterface

`default_nettype wire

// ==== source/ttc_prescaler.sv ====
`timescale 1ns/1ps
`default_nettype none

module ttc_prescaler import ttc_pkg::*; (
   input  logic      pclk,
   input  logic      arst_n,
   input  clk_ctrl_t clk_ctrl,
   input  logic      restart,   // Counter restart write
   output logic      tick
);

   clk_ctrl_t             ctrl_q;      // Setting seen last cycle
   count_t                div_q;
   count_t                div_last;
   logic [$bits(count_t):0] period;    // 2^(e+1), one bit above count_t
   logic                  pre_en;
   logic                  cfg_change;

   assign pre_en     = clk_ctrl[ck_pre_en];
   assign period     = (1 << 1) << clk_ctrl[ck_exp_msb:ck_exp_lsb];
   assign div_last   = count_t'(period - 1'b1);
   assign cfg_change = clk_ctrl != ctrl_q;

   // Every cycle when bypassed
   assign tick = !pre_en || (div_q == div_last && !cfg_change);

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         ctrl_q <= '0;
         div_q  <= '0;
      end else begin
         ctrl_q <= clk_ctrl;
         if (restart || cfg_change || !pre_en)
            div_q <= '0;                    // Start a fresh period
         else if (div_q == div_last)
            div_q <= '0;
         else
            div_q <= div_q + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== source/ttc_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ttc_timer import ttc_pkg::*; (
   input  logic     pclk,
   input  logic     arst_n,
   ttc_reg_if.timer regs,
   output logic     interrupt
);

   clk_ctrl_t  clk_ctrl_q;
   cntr_ctrl_t cntr_ctrl_q;      // Restart bit always held at 0
   count_t     interval_q;
   count_t     match_q;
   count_t     count_q;
   count_t     count_nxt;
   int_t       int_enable_q;
   int_t       int_status_q;
   int_t       int_event;
   int_t       int_clear;
   logic       restart;
   logic       tick;
   logic       step;
   logic       intv_hit, ovf_hit, match_hit;

   // ----------------------------------------
   // Configuration registers
   // ----------------------------------------
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         clk_ctrl_q   <= '0;
         cntr_ctrl_q  <= '0;
         interval_q   <= '0;
         match_q      <= '0;
         int_enable_q <= '0;
      end else begin
         if (regs.wr_strobe[stb_clk_ctrl])
            clk_ctrl_q <= regs.wdata[$bits(clk_ctrl_t)-1:0];
         if (regs.wr_strobe[stb_cntr_ctrl]) begin
            cntr_ctrl_q             <= regs.wdata[$bits(cntr_ctrl_t)-1:0];
            cntr_ctrl_q[cc_restart] <= 1'b0;         // Acts once then drops
         end
         if (regs.wr_strobe[stb_interval])
            interval_q <= regs.wdata;
         if (regs.wr_strobe[stb_match])
            match_q <= regs.wdata;
         if (regs.wr_strobe[stb_int_enable])
            int_enable_q <= regs.wdata[$bits(int_t)-1:0];
      end
   end

   assign restart = regs.wr_strobe[stb_cntr_ctrl] && regs.wdata[cc_restart];

   // Count tick source
   ttc_prescaler u_prescaler (
      .pclk     (pclk),
      .arst_n   (arst_n),
      .clk_ctrl (clk_ctrl_q),
      .restart  (restart),
      .tick     (tick)
   );

   // ----------------------------------------
   // Counter and wrap logic
   // ----------------------------------------
   assign step      = cntr_ctrl_q[cc_run] && tick && !restart;
   assign intv_hit  = step && cntr_ctrl_q[cc_interval] && (count_q == interval_q);
   assign ovf_hit   = step && !intv_hit && (count_q == '1);   // Full count wrap
   assign count_nxt = intv_hit ? '0 : count_q + 1'b1;
   assign match_hit = step && cntr_ctrl_q[cc_match_en] && (count_nxt == match_q);

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n)
         count_q <= '0;
      else if (restart)
         count_q <= '0;
      else if (step)
         count_q <= count_nxt;
   end

   // ----------------------------------------
   // Status and interrupt
   // ----------------------------------------
   always_comb begin
      int_event               = '0;
      int_event[int_overflow] = ovf_hit;
      int_event[int_interval] = intv_hit;
      int_event[int_match]    = match_hit;
   end

   // Read clears all, write clears the ones written
   always_comb begin
      if (regs.rd_clear)
         int_clear = '1;
      else if (regs.wr_strobe[stb_int_status])
         int_clear = regs.wdata[$bits(int_t)-1:0];
      else
         int_clear = '0;
   end

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         int_status_q <= '0;
         interrupt    <= 1'b0;
      end else begin
         int_status_q <= (int_status_q & ~int_clear) | int_event;  // Event wins
         interrupt    <= |(int_status_q & int_enable_q);
      end
   end

   // Read back
   assign regs.clk_ctrl   = clk_ctrl_q;
   assign regs.cntr_ctrl  = cntr_ctrl_q;
   assign regs.count      = count_q;
   assign regs.interval   = interval_q;
   assign regs.match      = match_q;
   assign regs.int_status = int_status_q;
   assign regs.int_enable = int_enable_q;

   a_irq_follows_status: assert property (@(posedge pclk) disable iff (!arst_n)
      interrupt |-> $past(|(int_status_q & int_enable_q)));

endmodule

`default_nettype wire

// ==== source/ttc_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ttc_apb_regs import ttc_pkg::*; (
   input  logic      pclk,
   input  logic      arst_n,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_addr_t paddr,
   input  apb_data_t pwdata,
   output apb_data_t prdata,
   ttc_reg_if.ctrl   tmr0,
   ttc_reg_if.ctrl   tmr1,
   ttc_reg_if.ctrl   tmr2
);

   apb_state_t  state_q, state_d;
   reg_kind_t   kind;
   logic [1:0]  tmr_idx;
   logic        access, wr_acc, rd_acc;
   reg_strobe_t strobe;
   apb_data_t   rd_val [num_timers];

   // ----------------------------------------
   // Phase tracker
   // ----------------------------------------
   always_comb begin
      state_d = apb_idle;
      case (state_q)
         apb_idle, apb_access: begin
            if (psel && !penable)
               state_d = apb_setup;      // New transfer, back to back allowed
         end
         apb_setup: begin
            if (psel && penable)
               state_d = apb_access;
         end
         default: state_d = apb_idle;
      endcase
   end

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n)
         state_q <= apb_idle;
      else
         state_q <= state_d;
   end

   // Access cycle only counts after a real setup cycle
   assign access = psel && penable && (state_q == apb_setup);
   assign wr_acc = access && pwrite;
   assign rd_acc = access && !pwrite;

   // ----------------------------------------
   // Address decode
   // ----------------------------------------
   assign kind    = reg_kind_t'(paddr[kind_msb:kind_lsb]);
   assign tmr_idx = paddr[tidx_msb:tidx_lsb];

   always_comb begin
      strobe = '0;
      case (kind)
         reg_clk_ctrl:   strobe[stb_clk_ctrl]   = 1'b1;
         reg_cntr_ctrl:  strobe[stb_cntr_ctrl]  = 1'b1;
         reg_interval:   strobe[stb_interval]   = 1'b1;
         reg_match:      strobe[stb_match]      = 1'b1;
         reg_int_status: strobe[stb_int_status] = 1'b1;
         reg_int_enable: strobe[stb_int_enable] = 1'b1;
         default:        strobe = '0;          // Count and unmapped kinds
      endcase
   end

   // Strobes and clears go to the addressed timer only
   assign tmr0.wr_strobe = (wr_acc && tmr_idx == 2'd0) ? strobe : '0;
   assign tmr1.wr_strobe = (wr_acc && tmr_idx == 2'd1) ? strobe : '0;
   assign tmr2.wr_strobe = (wr_acc && tmr_idx == 2'd2) ? strobe : '0;
   assign tmr0.wdata     = pwdata[$bits(count_t)-1:0];
   assign tmr1.wdata     = pwdata[$bits(count_t)-1:0];
   assign tmr2.wdata     = pwdata[$bits(count_t)-1:0];
   assign tmr0.rd_clear  = rd_acc && kind == reg_int_status && tmr_idx == 2'd0;
   assign tmr1.rd_clear  = rd_acc && kind == reg_int_status && tmr_idx == 2'd1;
   assign tmr2.rd_clear  = rd_acc && kind == reg_int_status && tmr_idx == 2'd2;

   // ----------------------------------------
   // Read mux
   // ----------------------------------------
   function automatic apb_data_t reg_value(input reg_kind_t k, input clk_ctrl_t ck,
                                           input cntr_ctrl_t cc, input count_t cnt,
                                           input count_t iv, input count_t mt,
                                           input int_t st, input int_t en);
      apb_data_t v;
      case (k)
         reg_clk_ctrl:   v = apb_data_t'(ck);     // Zero extended
         reg_cntr_ctrl:  v = apb_data_t'(cc);
         reg_count:      v = apb_data_t'(cnt);
         reg_interval:   v = apb_data_t'(iv);
         reg_match:      v = apb_data_t'(mt);
         reg_int_status: v = apb_data_t'(st);
         reg_int_enable: v = apb_data_t'(en);
         default:        v = '0;
      endcase
      return v;
   endfunction

   assign rd_val[0] = reg_value(kind, tmr0.clk_ctrl, tmr0.cntr_ctrl, tmr0.count,
                                tmr0.interval, tmr0.match, tmr0.int_status, tmr0.int_enable);
   assign rd_val[1] = reg_value(kind, tmr1.clk_ctrl, tmr1.cntr_ctrl, tmr1.count,
                                tmr1.interval, tmr1.match, tmr1.int_status, tmr1.int_enable);
   assign rd_val[2] = reg_value(kind, tmr2.clk_ctrl, tmr2.cntr_ctrl, tmr2.count,
                                tmr2.interval, tmr2.match, tmr2.int_status, tmr2.int_enable);

   // Zero outside read access and for index 3
   assign prdata = (rd_acc && int'(tmr_idx) < num_timers) ? rd_val[tmr_idx] : '0;

   // ----------------------------------------
   // Checks
   // ----------------------------------------
   a_setup_before_access: assert property (@(posedge pclk) disable iff (!arst_n)
      $rose(penable) |-> state_q == apb_setup);

   a_one_strobe: assert property (@(posedge pclk) disable iff (!arst_n)
      $onehot0({tmr0.wr_strobe, tmr1.wr_strobe, tmr2.wr_strobe}));

endmodule

`default_nettype wire

// ==== source/ttc_lite.sv ====
`timescale 1ns/1ps
`default_nettype none

module ttc_lite import ttc_pkg::*; (
   input  logic                  pclk,
   input  logic                  arst_n,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  apb_addr_t             paddr,
   input  apb_data_t             pwdata,
   output apb_data_t             prdata,
   output logic [num_timers-1:0] interrupt   // Bit n from timer n
);

   // ----------------------------------------
   // Register bundles, one per timer
   // ----------------------------------------
   ttc_reg_if tmr0_if ();
   ttc_reg_if tmr1_if ();
   ttc_reg_if tmr2_if ();

   // APB decode, no timer state here
   ttc_apb_regs u_regs (
      .pclk    (pclk),
      .arst_n  (arst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .tmr0    (tmr0_if),
      .tmr1    (tmr1_if),
      .tmr2    (tmr2_if)
   );

   // ----------------------------------------
   // Timers
   // ----------------------------------------
   ttc_timer u_tmr0 (
      .pclk      (pclk),
      .arst_n    (arst_n),
      .regs      (tmr0_if),
      .interrupt (interrupt[0])
   );

   ttc_timer u_tmr1 (
      .pclk      (pclk),
      .arst_n    (arst_n),
      .regs      (tmr1_if),
      .interrupt (interrupt[1])
   );

   ttc_timer u_tmr2 (
      .pclk      (pclk),
      .arst_n    (arst_n),
      .regs      (tmr2_if),
      .interrupt (interrupt[2])
   );

endmodule

`default_nettype wire

// ==== dv/ttc_lite_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ttc_lite_tb import ttc_pkg::*; ();

   typedef struct packed {
      logic       rd;        // 1 read and compare, 0 write
      apb_addr_t  addr;
      apb_data_t  data;
      apb_data_t  exp;
      logic [3:0] id;        // Test number
   } step_t;

   logic       pclk;
   logic       arst_n;
   logic       psel;
   logic       penable;
   logic       pwrite;
   apb_addr_t  paddr;
   apb_data_t  pwdata;
   apb_data_t  prdata;
   logic [2:0] interrupt;

   step_t      table_q[$];
   integer     seed;
   int         checks;
   int         errors;
   int         tests_run;
   int         test_err0;       // Errors before current test
   logic [2:0] irq_seen;        // Sticky OR of interrupt lines
   apb_data_t  rdata;
   int         iv;
   int         e_exp;
   int         n_run;

   ttc_lite u_dut (
      .pclk      (pclk),
      .arst_n    (arst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

   initial begin
      pclk = 1'b0;
      forever #20 pclk = ~pclk;      // 40 ns period
   end

   always @(negedge pclk)
      irq_seen <= irq_seen | interrupt;

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   function automatic apb_addr_t reg_addr(input int kind, input int idx);
      return apb_addr_t'((kind << 4) | (idx << 2));   // Kind in [7:4], timer in [3:2]
   endfunction

   // Write pattern per register and timer
   function automatic apb_data_t wr_val(input int kind, input int t);
      case (kind)
         0:       return 32'hFFFF_FF00 | (32'h13 + 5 * t);
         1:       return 32'hFFFF_FF0E ^ (t << 2);          // Run bit kept 0
         3:       return 32'hDEAD_1234 + t;
         4:       return 32'hBEEF_8001 + t * 32'h111;
         default: return 32'hFFFF_FFF8 | (t + 1);
      endcase
   endfunction

   // Readable bits of each register
   function automatic apb_data_t rd_mask(input int kind);
      case (kind)
         0:       return 32'h1F;
         1:       return 32'h7;       // Restart never reads back
         3, 4:    return 32'hFFFF;
         default: return 32'h7;
      endcase
   endfunction

   task automatic add_step(input logic rd, input apb_addr_t addr, input apb_data_t data,
                           input apb_data_t exp, input int id);
      step_t s;
      s.rd   = rd;
      s.addr = addr;
      s.data = data;
      s.exp  = exp;
      s.id   = id[3:0];
      table_q.push_back(s);
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
      @(posedge pclk);
      psel    <= 1'b1;              // Setup
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge pclk);
      penable <= 1'b1;              // Access
      @(posedge pclk);              // Register loads here
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
      @(posedge pclk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge pclk);
      penable <= 1'b1;
      @(negedge pclk);              // prdata settled mid access
      data = prdata;
      @(posedge pclk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic check_value(input string name, input apb_data_t got, input apb_data_t exp);
      checks++;
      assert (got === exp) else begin
         $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_near(input string name, input apb_data_t got, input int exp);
      int diff;
      diff = int'(got) - exp;
      checks++;
      assert (diff >= -1 && diff <= 1) else begin
         $display("MISMATCH at %0t ns: %s is %0d, expected %0d give or take 1",
                  $time, name, got, exp);
         errors++;
      end
   endtask

   // Poll one interrupt line, bounded
   task automatic wait_irq(input int bit_n, input logic level, input int limit);
      int   n;
      logic hit;
      n   = 0;
      hit = 1'b0;
      while (!hit && n < limit) begin
         @(negedge pclk);
         hit = (interrupt[bit_n] === level);
         n++;
      end
      if (!hit) begin
         $display("ERROR at %0t ns: interrupt %0d did not go to %0d within %0d cycles",
                  $time, bit_n, level, limit);
         errors++;
      end
      @(posedge pclk);              // Back on the drive edge
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge pclk);
   endtask

   task automatic run_table(input int id);
      apb_data_t got;
      foreach (table_q[i]) begin
         if (table_q[i].id == id) begin
            if (table_q[i].rd) begin
               apb_read(table_q[i].addr, got);
               check_value($sformatf("prdata @ 0x%h", table_q[i].addr), got, table_q[i].exp);
            end else begin
               apb_write(table_q[i].addr, table_q[i].data);
            end
         end
      end
   endtask

   task automatic end_test(input int id, input string name);
      tests_run++;
      $display("test %0d %s: %s, %0d errors", id, name,
               (errors == test_err0) ? "ok" : "failed", errors - test_err0);
      test_err0 = errors;
   endtask

   // ----------------------------------------
   // Register table, tests 1 and 2
   // ----------------------------------------
   task automatic build_table();
      int t;
      int k;
      for (t = 0; t < 3; t++)
         for (k = 0; k < 7; k++)
            add_step(1'b1, reg_addr(k, t), '0, '0, 1);       // Reset values
      for (t = 0; t < 3; t++)
         for (k = 0; k < 7; k++)
            if (k != 2 && k != 5)
               add_step(1'b0, reg_addr(k, t), wr_val(k, t), '0, 1);
      for (t = 0; t < 3; t++)
         for (k = 0; k < 7; k++)
            if (k != 2 && k != 5)
               add_step(1'b1, reg_addr(k, t), '0, wr_val(k, t) & rd_mask(k), 1);
      for (k = 7; k < 16; k++)
         add_step(1'b1, reg_addr(k, 0), '0, '0, 2);          // Unmapped kinds
      for (k = 0; k < 7; k++)
         add_step(1'b1, reg_addr(k, 3), '0, '0, 2);          // Timer index 3
      add_step(1'b0, reg_addr(2, 0), 32'h0000_BEEF, '0, 2);  // Count is read only
      add_step(1'b1, reg_addr(2, 0), '0, '0, 2);
      for (t = 0; t < 3; t++)
         for (k = 0; k < 7; k++)
            if (k != 2 && k != 5)
               add_step(1'b0, reg_addr(k, t), '0, '0, 2);    // Back to idle
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin
      seed      = 99013;
      checks    = 0;
      errors    = 0;
      tests_run = 0;
      test_err0 = 0;
      irq_seen  = '0;
      arst_n    = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      repeat (4) @(posedge pclk);
      arst_n <= 1'b1;

      build_table();
      run_table(1);
      end_test(1, "reset and readback");
      run_table(2);
      end_test(2, "map edges");

      // Interval mode on timer 1
      iv = 1 + ({$random(seed)} % 40);
      apb_write(reg_addr(reg_int_enable, 1), 32'h2);
      apb_write(reg_addr(reg_interval, 1), iv);
      apb_write(reg_addr(reg_clk_ctrl, 1), 32'h0);
      irq_seen = '0;
      apb_write(reg_addr(reg_cntr_ctrl, 1), 32'hB);       // Run, interval, restart
      wait_irq(1, 1'b1, 4 * (iv + 1) + 16);
      apb_write(reg_addr(reg_cntr_ctrl, 1), 32'h2);       // Stop
      apb_read(reg_addr(reg_int_status, 1), rdata);
      check_value("int_status[1]", rdata, 32'h2);
      apb_read(reg_addr(reg_int_status, 1), rdata);
      check_value("int_status[1] after clear", rdata, 32'h0);
      wait_irq(1, 1'b0, 8);
      check_value("interrupt lines seen", apb_data_t'(irq_seen), 32'h2);
      end_test(3, "interval mode");

      // Match flag on timer 2, interval 20
      apb_write(reg_addr(reg_interval, 2), 32'd20);
      apb_write(reg_addr(reg_match, 2), 32'd7);
      apb_write(reg_addr(reg_int_enable, 2), 32'h4);
      apb_write(reg_addr(reg_cntr_ctrl, 2), 32'hF);       // Match enable on
      wait_irq(2, 1'b1, 64);
      apb_write(reg_addr(reg_cntr_ctrl, 2), 32'h6);
      apb_read(reg_addr(reg_int_status, 2), rdata);
      check_value("int_status[2]", rdata, 32'h4);
      wait_irq(2, 1'b0, 8);
      apb_write(reg_addr(reg_cntr_ctrl, 2), 32'hB);       // Match enable off
      wait_cycles(2 * 21 + 4);
      apb_write(reg_addr(reg_cntr_ctrl, 2), 32'h2);
      apb_read(reg_addr(reg_int_status, 2), rdata);
      check_value("int_status[2] match bit", rdata & 32'h4, 32'h0);
      apb_write(reg_addr(reg_int_enable, 2), 32'h0);      // Mask the line
      irq_seen = '0;
      apb_write(reg_addr(reg_cntr_ctrl, 2), 32'hF);
      wait_cycles(2 * 21 + 4);
      apb_write(reg_addr(reg_cntr_ctrl, 2), 32'h6);
      check_value("interrupt lines seen", apb_data_t'(irq_seen), 32'h0);
      apb_write(reg_addr(reg_int_enable, 2), 32'h4);      // Held flag shows up now
      wait_irq(2, 1'b1, 8);
      apb_read(reg_addr(reg_int_status, 2), rdata);
      check_value("int_status[2] match bit", rdata & 32'h4, 32'h4);
      wait_irq(2, 1'b0, 8);
      end_test(4, "match flag");

      // Prescaler on timer 0, N cycles between restart and stop
      e_exp = 2;
      n_run = 200;
      apb_write(reg_addr(reg_clk_ctrl, 0), (e_exp << 1) | 1);
      apb_write(reg_addr(reg_cntr_ctrl, 0), 32'h9);       // Run and restart
      wait_cycles(n_run - 3);                             // Stop write adds 3
      apb_write(reg_addr(reg_cntr_ctrl, 0), 32'h0);
      apb_read(reg_addr(reg_count, 0), rdata);
      check_near("count[0] prescaled", rdata, n_run >> (e_exp + 1));
      apb_write(reg_addr(reg_clk_ctrl, 0), 32'h0);
      apb_write(reg_addr(reg_cntr_ctrl, 0), 32'h9);
      wait_cycles(n_run - 3);
      apb_write(reg_addr(reg_cntr_ctrl, 0), 32'h0);
      apb_read(reg_addr(reg_count, 0), rdata);
      check_near("count[0] direct", rdata, n_run);
      end_test(5, "prescaler");

      // Overflow on timer 1, full 16 bit run
      apb_write(reg_addr(reg_match, 1), 32'hFFF0);
      apb_write(reg_addr(reg_int_enable, 1), 32'h1);
      apb_write(reg_addr(reg_cntr_ctrl, 1), 32'hD);       // Run, match enable, restart
      wait_irq(1, 1'b1, 65536 + 64);
      apb_write(reg_addr(reg_cntr_ctrl, 1), 32'h0);
      apb_read(reg_addr(reg_int_status, 1), rdata);
      check_value("int_status[1]", rdata, 32'h5);         // Match passed before wrap
      wait_irq(1, 1'b0, 8);
      end_test(6, "overflow");

      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== ttc_lite.f ====
source/ttc_pkg.sv
source/ttc_reg_if.sv
source/ttc_prescaler.sv
source/ttc_timer.sv
source/ttc_apb_regs.sv
source/ttc_lite.sv
dv/ttc_lite_tb.sv

// ==== Bender.yml ====
package:
  name: ttc_lite

# Compile order follows ttc_lite.f
sources:
  # Package and register interface first
  - source/ttc_pkg.sv
  - source/ttc_reg_if.sv

  # Timer datapath, decoder, top level
  - source/ttc_prescaler.sv
  - source/ttc_timer.sv
  - source/ttc_apb_regs.sv
  - source/ttc_lite.sv

  # Simulation only
  - target: dv
    files:
      - dv/ttc_lite_tb.sv
